/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_fetch_unit
FILELIST := flist.f
OBJ_DIR  := obj_dir
LOG      := sim.log
FAIL_MSG := Something failed
PASS_MSG := Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "RESULT: FAIL"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "RESULT: FAIL (run ended early)"; exit 1; \
	else \
		echo "RESULT: PASS"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/clock_gen.sv */
`default_nettype none

module clock_gen (
    output logic clk
);
    // 40 unit period
    localparam int HALF_PERIOD = 20;

    // Starts low, free-running
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

`default_nettype wire

/* bench/fetch_props.sv */
`default_nettype none

module fetch_props (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   flush,
    input logic                   push,
    input logic                   pop,
    input logic                   credit_return,
    input fetch_pkg::fq_state_e   state_q
);
    import fetch_pkg::*;

    // Shadow count of queue entries
    int occupancy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occupancy <= 0;
        end else if (flush) begin
            // Everything dropped
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + int'(push) - int'(credit_return);
        end
    end

    // Credits make a push into a full queue impossible
    no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        (state_q == FQ_FULL) |-> !push)
        else $error("push seen while the fetch queue is full");

    // Each pop outside a flush returns one credit and nothing else does
    credit_per_pop: assert property (@(posedge clk) disable iff (!rst_n)
        credit_return == (pop && !flush))
        else $error("credit_return does not match pop");

    occupancy_bound: assert property (@(posedge clk) disable iff (!rst_n)
        (occupancy >= 0) && (occupancy <= FQ_DEPTH))
        else $error("fetch queue occupancy out of range: %0d", occupancy);

    // Occupancy FSM agrees with the count
    state_matches_count: assert property (@(posedge clk) disable iff (!rst_n)
        ((occupancy == 0) == (state_q == FQ_EMPTY)) &&
        ((occupancy == FQ_DEPTH) == (state_q == FQ_FULL)))
        else $error("fetch queue state disagrees with occupancy %0d", occupancy);

endmodule

`default_nettype wire

/* bench/tb_fetch_unit.sv */
`default_nettype none

module tb_fetch_unit;
    import fetch_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam logic [31:0] LFSR_SEED = 32'h2d22;

    // Program table of address, word and expected class
    localparam int PROG_LEN = 8;
    localparam addr_t PROG_ADDR [PROG_LEN] = '{
        32'h00, 32'h04, 32'h08, 32'h18, 32'h1C, 32'h20, 32'h24, 32'h50};
    localparam instr_t PROG_INSTR [PROG_LEN] = '{
        32'h00100093,   // addi x1, x0, 1
        32'h00200113,   // addi x2, x0, 2
        32'h0100006F,   // jal x0, +16
        32'h00000663,   // beq x0, x0, +12 forward
        32'h00008067,   // jalr x0, 0(x1)
        32'h00300193,   // addi x3, x0, 3
        32'hFE209CE3,   // bne x1, x2, -8 backward
        32'hFF1FF06F};  // jal x0, -16
    localparam instr_class_e PROG_CLASS [PROG_LEN] = '{
        CLS_OTHER, CLS_OTHER, CLS_JAL, CLS_BRANCH,
        CLS_JALR, CLS_OTHER, CLS_BRANCH, CLS_JAL};

    // Redirect table of accepted output count and target
    localparam int REDIR_LEN = 3;
    localparam int    REDIR_COUNT [REDIR_LEN] = '{10, 22, 31};
    localparam addr_t REDIR_PC    [REDIR_LEN] = '{32'h40, 32'h100, 32'h18};

    localparam int NUM_OUTPUTS = 40;
    localparam int WATCHDOG_CYCLES = (NUM_OUTPUTS + REDIR_LEN) * 20 + RESET_CYCLES;

    logic         clk;
    logic         rst_n;
    addr_t        imem_addr;
    instr_t       imem_rdata;
    logic         redirect_valid;
    addr_t        redirect_pc;
    logic         out_valid;
    logic         out_ready;
    addr_t        out_pc;
    instr_t       out_instr;
    logic         out_pred_taken;
    addr_t        out_next_pc;
    instr_class_e out_class;

    // 1 KB instruction memory
    instr_t       imem [0:255];
    logic [31:0]  lfsr;
    addr_t        exp_pc;
    int           out_count;
    int           check_count;
    int           error_count;

    clock_gen clock_gen_inst (
        .clk (clk)
    );

    fetch_unit fetch_unit_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .imem_addr      (imem_addr),
        .imem_rdata     (imem_rdata),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_pc         (out_pc),
        .out_instr      (out_instr),
        .out_pred_taken (out_pred_taken),
        .out_next_pc    (out_next_pc),
        .out_class      (out_class)
    );

    bind fetch_queue fetch_props fetch_props_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .push          (push),
        .pop           (pop),
        .credit_return (credit_return),
        .state_q       (state_q)
    );

    // Unloaded words get an OP-IMM encoding mixed from the whole address
    function automatic instr_t fill_word(input addr_t addr);
        return {addr[31:7] ^ addr[24:0], 7'b0010011};
    endfunction

    // Combinational read
    assign imem_rdata = (imem_addr < 32'h400) ? imem[imem_addr[9:2]] : fill_word(imem_addr);

    task automatic load_memory();
        for (int i = 0; i < 256; i++) begin
            imem[i] = fill_word(32'(i) << 2);
        end
        for (int p = 0; p < PROG_LEN; p++) begin
            imem[PROG_ADDR[p][9:2]] = PROG_INSTR[p];
        end
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Ready about a quarter of the time so the queue fills
    task automatic draw_ready(output logic ready);
        logic a;
        lfsr = lfsr_step(lfsr);
        a = lfsr[0];
        lfsr = lfsr_step(lfsr);
        ready = a & lfsr[0];
    endtask

    // Static prediction per the RV32I offset layouts
    task automatic ref_predict(input addr_t pc, input instr_t w,
                               output addr_t nxt, output logic taken);
        int off;
        nxt = pc + 32'd4;
        taken = 1'b0;
        if (w[6:0] == 7'b1101111) begin
            off = int'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
            nxt = pc + addr_t'(off);
            taken = 1'b1;
        end else if (w[6:0] == 7'b1100011) begin
            off = int'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
            // Backward only
            if (off < 0) begin
                nxt = pc + addr_t'(off);
                taken = 1'b1;
            end
        end
    endtask

    function automatic instr_class_e expected_class(input addr_t addr);
        instr_class_e cls;
        cls = CLS_OTHER;
        for (int p = 0; p < PROG_LEN; p++) begin
            if (PROG_ADDR[p] == addr) begin
                cls = PROG_CLASS[p];
            end
        end
        return cls;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("CHECK FAILED %s: got %h expected %h (output %0d)",
                     name, got, exp, out_count);
        end
    endtask

    // Compare one accepted output and step the model
    task automatic check_output();
        instr_t       exp_instr;
        addr_t        exp_next;
        logic         exp_taken;
        instr_class_e exp_cls;
        exp_instr = (exp_pc < 32'h400) ? imem[exp_pc[9:2]] : fill_word(exp_pc);
        ref_predict(exp_pc, exp_instr, exp_next, exp_taken);
        exp_cls = expected_class(exp_pc);
        check_value("out_pc", out_pc, exp_pc);
        check_value("out_instr", out_instr, exp_instr);
        check_value("out_pred_taken", 32'(out_pred_taken), 32'(exp_taken));
        check_value("out_next_pc", out_next_pc, exp_next);
        check_value("out_class", 32'(out_class), 32'(exp_cls));
        exp_pc = exp_next;
    endtask

    initial begin
        int         redir_idx;
        logic       fire;
        logic       stalled;
        logic       ready_bit;
        logic [98:0] held;
        rst_n          = 1'b0;
        out_ready      = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        lfsr           = LFSR_SEED;
        out_count      = 0;
        check_count    = 0;
        error_count    = 0;
        redir_idx      = 0;
        stalled        = 1'b0;
        held           = '0;
        exp_pc         = RESET_PC;
        load_memory();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        while (out_count < NUM_OUTPUTS) begin
            // Sample mid-cycle
            @(negedge clk);
            fire = out_valid && out_ready;
            // Valid and payload both hold while stalled
            if (stalled) begin
                check_count++;
                assert (out_valid &&
                        ({out_pc, out_instr, out_pred_taken, out_next_pc, out_class} == held))
                else begin
                    error_count++;
                    $display("Output dropped or changed while stalled before output %0d",
                             out_count);
                end
            end
            stalled = out_valid && !out_ready && !redirect_valid;
            held = {out_pc, out_instr, out_pred_taken, out_next_pc, out_class};
            if (fire) begin
                check_output();
                out_count++;
            end
            @(posedge clk);
            if (fire && redir_idx < REDIR_LEN && out_count == REDIR_COUNT[redir_idx]) begin
                // One-cycle redirect with nothing accepted alongside
                redirect_valid <= 1'b1;
                redirect_pc    <= REDIR_PC[redir_idx];
                out_ready      <= 1'b0;
                exp_pc = REDIR_PC[redir_idx];
                redir_idx++;
            end else begin
                draw_ready(ready_bit);
                redirect_valid <= 1'b0;
                out_ready      <= ready_bit;
            end
        end
        $display("Checks: %0d  Errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Bound on total run length
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles with %0d of %0d outputs seen",
                 WATCHDOG_CYCLES, out_count, NUM_OUTPUTS);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
rtl/fetch_pkg.sv
rtl/next_pc_predictor.sv
rtl/fetch_stage.sv
rtl/fetch_queue.sv
rtl/decode_stage.sv
rtl/fetch_unit.sv
bench/clock_gen.sv
bench/fetch_props.sv
bench/tb_fetch_unit.sv

/* rtl/decode_stage.sv */
`default_nettype none

module decode_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic                    q_valid,
    input  fetch_pkg::addr_t        q_pc,
    input  fetch_pkg::instr_t       q_instr,
    input  logic                    q_pred_taken,
    input  fetch_pkg::addr_t        q_next_pc,
    output logic                    pop,
    output logic                    out_valid,
    input  logic                    out_ready,
    output fetch_pkg::addr_t        out_pc,
    output fetch_pkg::instr_t       out_instr,
    output logic                    out_pred_taken,
    output fetch_pkg::addr_t        out_next_pc,
    output fetch_pkg::instr_class_e out_class
);
    import fetch_pkg::*;

    logic         valid_q;
    instr_class_e q_class;

    // Classify the head entry
    assign q_class = classify_opcode(q_instr[6:0]);

    // Take a new entry if the slot is free or drains this cycle
    // Never pop during a flush
    assign pop = q_valid && !flush && (!valid_q || out_ready);

    assign out_valid = valid_q;

    // Output valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;
        end else if (pop) begin
            valid_q <= 1'b1;
        end else if (out_ready) begin
            // Accepted with nothing behind it
            valid_q <= 1'b0;
        end
    end

    // Output payload
    // Loads only on pop so it holds while stalled
    always_ff @(posedge clk) begin
        if (pop) begin
            out_pc         <= q_pc;
            out_instr      <= q_instr;
            out_pred_taken <= q_pred_taken;
            out_next_pc    <= q_next_pc;
            out_class      <= q_class;
        end
    end

endmodule

`default_nettype wire

/* rtl/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    // Datapath widths
    localparam int ADDR_W  = 32;
    localparam int INSTR_W = 32;
    localparam int OPC_W   = 7;

    // PC or byte address
    typedef logic [ADDR_W-1:0]  addr_t;
    // Raw RV32I instruction word
    typedef logic [INSTR_W-1:0] instr_t;
    // Major opcode field, instr[6:0]
    typedef logic [OPC_W-1:0]   opcode_t;

    // Fetch queue depth
    // Also the number of credits fetch owns out of reset
    localparam int FQ_DEPTH = 4;
    localparam int FQ_PTR_W = $clog2(FQ_DEPTH);
    localparam int CREDIT_W = $clog2(FQ_DEPTH + 1);

    // Queue slot index
    typedef logic [FQ_PTR_W-1:0] fq_ptr_t;
    // Holds 0 to FQ_DEPTH inclusive
    typedef logic [CREDIT_W-1:0] credit_t;

    // First fetch address
    localparam addr_t RESET_PC = 32'h0000_0000;

    // Control-flow opcodes
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;

    // Instruction classes seen by the front end
    typedef enum logic [1:0] {
        CLS_OTHER,
        CLS_BRANCH,
        CLS_JAL,
        CLS_JALR
    } instr_class_e;

    // Fetch queue occupancy
    typedef enum logic [1:0] {
        FQ_EMPTY,
        FQ_PARTIAL,
        FQ_FULL
    } fq_state_e;

    // Opcode to class, shared by predictor and decode
    function automatic instr_class_e classify_opcode(input opcode_t opc);
        instr_class_e cls;
        case (opc)
            OPC_BRANCH: cls = CLS_BRANCH;
            OPC_JAL:    cls = CLS_JAL;
            OPC_JALR:   cls = CLS_JALR;
            default:    cls = CLS_OTHER;
        endcase
        return cls;
    endfunction

endpackage

`default_nettype wire

/* rtl/fetch_queue.sv */
`default_nettype none

module fetch_queue (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  logic              push,
    input  fetch_pkg::addr_t  push_pc,
    input  fetch_pkg::instr_t push_instr,
    input  logic              push_pred_taken,
    input  fetch_pkg::addr_t  push_next_pc,
    input  logic              pop,
    output logic              q_valid,
    output fetch_pkg::addr_t  q_pc,
    output fetch_pkg::instr_t q_instr,
    output logic              q_pred_taken,
    output fetch_pkg::addr_t  q_next_pc,
    output logic              credit_return
);
    import fetch_pkg::*;

    // Entry storage
    addr_t  pc_mem        [FQ_DEPTH];
    instr_t instr_mem     [FQ_DEPTH];
    logic   pred_mem      [FQ_DEPTH];
    addr_t  next_pc_mem   [FQ_DEPTH];

    fq_ptr_t   wr_ptr_q;
    fq_ptr_t   rd_ptr_q;
    fq_ptr_t   wr_ptr_inc;
    fq_ptr_t   rd_ptr_inc;
    fq_state_e state_q;
    logic      do_pop;

    // Wrapping increments
    assign wr_ptr_inc = (wr_ptr_q == fq_ptr_t'(FQ_DEPTH - 1)) ? '0 : wr_ptr_q + fq_ptr_t'(1);
    assign rd_ptr_inc = (rd_ptr_q == fq_ptr_t'(FQ_DEPTH - 1)) ? '0 : rd_ptr_q + fq_ptr_t'(1);

    // Pop only counts when something is there
    assign do_pop = pop && (state_q != FQ_EMPTY) && !flush;

    // Head of queue
    assign q_valid      = (state_q != FQ_EMPTY);
    assign q_pc         = pc_mem[rd_ptr_q];
    assign q_instr      = instr_mem[rd_ptr_q];
    assign q_pred_taken = pred_mem[rd_ptr_q];
    assign q_next_pc    = next_pc_mem[rd_ptr_q];

    // Freed slot goes back to fetch
    // Dropped entries on flush return nothing
    assign credit_return = do_pop;

    // Payload write
    always_ff @(posedge clk) begin
        if (push && !flush) begin
            pc_mem[wr_ptr_q]      <= push_pc;
            instr_mem[wr_ptr_q]   <= push_instr;
            pred_mem[wr_ptr_q]    <= push_pred_taken;
            next_pc_mem[wr_ptr_q] <= push_next_pc;
        end
    end

    // Pointers and occupancy FSM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            state_q  <= FQ_EMPTY;
        end else if (flush) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            state_q  <= FQ_EMPTY;
        end else if (push && !do_pop) begin
            wr_ptr_q <= wr_ptr_inc;
            state_q  <= (wr_ptr_inc == rd_ptr_q) ? FQ_FULL : FQ_PARTIAL;
        end else if (do_pop && !push) begin
            rd_ptr_q <= rd_ptr_inc;
            state_q  <= (rd_ptr_inc == wr_ptr_q) ? FQ_EMPTY : FQ_PARTIAL;
        end else if (push && do_pop) begin
            // Occupancy unchanged
            wr_ptr_q <= wr_ptr_inc;
            rd_ptr_q <= rd_ptr_inc;
        end
    end

endmodule

`default_nettype wire

/* rtl/fetch_stage.sv */
`default_nettype none

module fetch_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              redirect_valid,
    input  fetch_pkg::addr_t  redirect_pc,
    output fetch_pkg::addr_t  imem_addr,
    input  fetch_pkg::instr_t imem_rdata,
    input  logic              credit_return,
    output logic              push,
    output fetch_pkg::addr_t  push_pc,
    output fetch_pkg::instr_t push_instr,
    output logic              push_pred_taken,
    output fetch_pkg::addr_t  push_next_pc
);
    import fetch_pkg::*;

    addr_t   pc_q;
    credit_t credits_q;
    credit_t credits_d;
    addr_t   pred_next_pc;
    logic    pred_taken;

    // Predict from the word returned this cycle
    // Class and conditional flag are only needed downstream in decode
    next_pc_predictor predictor_inst (
        .pc             (pc_q),
        .instr          (imem_rdata),
        .next_pc        (pred_next_pc),
        .pred_taken     (pred_taken),
        .is_cond_branch (),
        .instr_class    ()
    );

    // Memory read is combinational
    assign imem_addr = pc_q;

    // Push needs a credit
    // A redirect kills the word fetched this cycle
    assign push = (credits_q != '0) && !redirect_valid;

    assign push_pc         = pc_q;
    assign push_instr      = imem_rdata;
    assign push_pred_taken = pred_taken;
    assign push_next_pc    = pred_next_pc;

    // One credit spent per push
    // One credit back per queue pop
    // Credits plus queue occupancy stay at FQ_DEPTH
    always_comb begin
        credits_d = credits_q;
        if (push) begin
            credits_d = credits_d - credit_t'(1);
        end
        if (credit_return) begin
            credits_d = credits_d + credit_t'(1);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q      <= RESET_PC;
            credits_q <= credit_t'(FQ_DEPTH);
        end else if (redirect_valid) begin
            // Queue is flushed so every credit comes home
            pc_q      <= redirect_pc;
            credits_q <= credit_t'(FQ_DEPTH);
        end else begin
            // Stall holds the PC when out of credits
            if (push) begin
                pc_q <= pred_next_pc;
            end
            credits_q <= credits_d;
        end
    end

endmodule

`default_nettype wire

/* rtl/fetch_unit.sv */
`default_nettype none

module fetch_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    // Instruction memory
    output fetch_pkg::addr_t        imem_addr,
    input  fetch_pkg::instr_t       imem_rdata,
    // Redirect from branch resolution
    input  logic                    redirect_valid,
    input  fetch_pkg::addr_t        redirect_pc,
    // Decoded output
    output logic                    out_valid,
    input  logic                    out_ready,
    output fetch_pkg::addr_t        out_pc,
    output fetch_pkg::instr_t       out_instr,
    output logic                    out_pred_taken,
    output fetch_pkg::addr_t        out_next_pc,
    output fetch_pkg::instr_class_e out_class
);
    import fetch_pkg::*;

    // Fetch to queue
    logic   push;
    addr_t  push_pc;
    instr_t push_instr;
    logic   push_pred_taken;
    addr_t  push_next_pc;
    logic   credit_return;

    // Queue to decode
    logic   q_valid;
    addr_t  q_pc;
    instr_t q_instr;
    logic   q_pred_taken;
    addr_t  q_next_pc;
    logic   pop;

    // Producer
    fetch_stage fetch_stage_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .imem_addr       (imem_addr),
        .imem_rdata      (imem_rdata),
        .credit_return   (credit_return),
        .push            (push),
        .push_pc         (push_pc),
        .push_instr      (push_instr),
        .push_pred_taken (push_pred_taken),
        .push_next_pc    (push_next_pc)
    );

    // Buffer, flushed by redirect
    fetch_queue fetch_queue_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush           (redirect_valid),
        .push            (push),
        .push_pc         (push_pc),
        .push_instr      (push_instr),
        .push_pred_taken (push_pred_taken),
        .push_next_pc    (push_next_pc),
        .pop             (pop),
        .q_valid         (q_valid),
        .q_pc            (q_pc),
        .q_instr         (q_instr),
        .q_pred_taken    (q_pred_taken),
        .q_next_pc       (q_next_pc),
        .credit_return   (credit_return)
    );

    // Consumer
    decode_stage decode_stage_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (redirect_valid),
        .q_valid        (q_valid),
        .q_pc           (q_pc),
        .q_instr        (q_instr),
        .q_pred_taken   (q_pred_taken),
        .q_next_pc      (q_next_pc),
        .pop            (pop),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_pc         (out_pc),
        .out_instr      (out_instr),
        .out_pred_taken (out_pred_taken),
        .out_next_pc    (out_next_pc),
        .out_class      (out_class)
    );

endmodule

`default_nettype wire

/* rtl/next_pc_predictor.sv */
`default_nettype none

module next_pc_predictor (
    input  fetch_pkg::addr_t       pc,
    input  fetch_pkg::instr_t      instr,
    output fetch_pkg::addr_t       next_pc,
    output logic                   pred_taken,
    output logic                   is_cond_branch,
    output fetch_pkg::instr_class_e instr_class
);
    import fetch_pkg::*;

    opcode_t opcode;
    addr_t   j_imm;
    addr_t   b_imm;
    addr_t   pc_plus4;
    addr_t   jal_target;
    addr_t   br_target;

    assign opcode = instr[6:0];

    // J-type offset, bit 0 always zero
    // imm[20|10:1|11|19:12] sits in instr[31:12]
    assign j_imm = {{11{instr[31]}},
                    instr[31],
                    instr[19:12],
                    instr[20],
                    instr[30:21],
                    1'b0};

    // B-type offset, bit 0 always zero
    // imm[12|10:5] in instr[31:25], imm[4:1|11] in instr[11:7]
    assign b_imm = {{19{instr[31]}},
                    instr[31],
                    instr[7],
                    instr[30:25],
                    instr[11:8],
                    1'b0};

    // Candidate targets
    assign pc_plus4   = pc + 32'd4;
    assign jal_target = pc + j_imm;
    assign br_target  = pc + b_imm;

    assign instr_class = classify_opcode(opcode);

    // Only B-type is conditional
    assign is_cond_branch = (instr_class == CLS_BRANCH);

    // Static prediction
    // JAL always taken, backward branch taken, forward branch not
    // JALR target unknown here so it falls through
    always_comb begin
        next_pc    = pc_plus4;
        pred_taken = 1'b0;
        case (instr_class)
            CLS_JAL: begin
                next_pc    = jal_target;
                pred_taken = 1'b1;
            end
            CLS_BRANCH: begin
                // Sign bit set means a backward offset
                if (b_imm[ADDR_W-1]) begin
                    next_pc    = br_target;
                    pred_taken = 1'b1;
                end
            end
            default: begin
                next_pc    = pc_plus4;
                pred_taken = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire
